// ==== verilog/lockPkg.sv ====
package lockPkg;

	// one key or code digit
	typedef logic [3:0] hexDigitT;

	// three digits, digit 0 in the low nibble
	typedef logic [11:0] codeWordT;

	// display glyph code
	typedef logic [3:0] glyphT;

	// g..a in bits 6..0, bit 7 is the decimal point
	typedef logic [7:0] segmentsT;

	// active-low digit selects
	typedef logic [3:0] digitSelT;

	// wrong-entry counter
	typedef logic [3:0] triesT;

	// numerals use their own value as glyph code
	localparam glyphT glyphP     = 4'd10;
	localparam glyphT glyphDash  = 4'd13;
	localparam glyphT glyphBlank = 4'd15;

	typedef enum logic [1:0]
	{
		CLOSED,
		OPEN,
		LOCKOUT
	} lockStateT;

	// four display positions, digit3 is the leftmost
	typedef struct packed
	{
		glyphT digit3;  // status glyph
		glyphT digit2;  // oldest entered digit
		glyphT digit1;
		glyphT digit0;  // newest entered digit
	} displayT;

endpackage

// ==== verilog/codeEntry.sv ====
module codeEntry
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             keyValid,
	input  lockPkg::hexDigitT keyValue,
	input  logic             clear,
	input  logic             flush,
	input  logic             keyEnable,
	output lockPkg::codeWordT entryCode,
	output logic [1:0]       entryCount
);

	lockPkg::codeWordT shiftReg;
	logic [1:0]        fillCount;
	logic              empty;
	logic              takeKey;

	// clear and flush both win over a key in the same cycle
	assign empty   = clear || flush;
	assign takeKey = keyValid && keyEnable && !empty;

	// digit shift, newest digit at the bottom
	always_ff @(posedge CLK)
	begin
		if (takeKey)
		begin
			shiftReg <= {shiftReg[7:0], keyValue};  // oldest digit falls off the top
		end
	end

	// fill count, saturates at three digits
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			fillCount <= 2'd0;
		end
		else if (empty)
		begin
			fillCount <= 2'd0;
		end
		else if (takeKey)
		begin
			if (fillCount != 2'd3)
			begin
				fillCount <= fillCount + 2'd1;
			end
		end
	end

	assign entryCode  = shiftReg;
	assign entryCount = fillCount;

endmodule

// ==== verilog/lockController.sv ====
module lockController
#(
	parameter lockPkg::codeWordT secretCode = 12'h000,
	parameter lockPkg::triesT    maxTries   = 4'd6
)
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              enter,
	input  lockPkg::codeWordT entryCode,
	input  logic [1:0]        entryCount,
	output logic              entryFlush,
	output logic              keyEnable,
	output logic              unlocked,
	output logic              lockedOut,
	output lockPkg::displayT  display
);

	lockPkg::lockStateT state;
	lockPkg::lockStateT nextState;
	lockPkg::triesT     tries;
	lockPkg::triesT     nextTries;
	lockPkg::triesT     triesInc;
	logic               match;
	lockPkg::glyphT     statusGlyph;

	// a short entry never matches
	assign match    = (entryCount == 2'd3) && (entryCode == secretCode);
	assign triesInc = tries + 4'd1;

	always_comb
	begin
		nextState = state;
		nextTries = tries;
		if (enter)
		begin
			case (state)
				lockPkg::CLOSED:
				begin
					if (match)
					begin
						nextState = lockPkg::OPEN;
						nextTries = 4'd0;
					end
					else
					begin
						nextTries = triesInc;
						if (triesInc >= maxTries)
						begin
							nextState = lockPkg::LOCKOUT;
						end
					end
				end
				lockPkg::OPEN:
				begin
					nextState = lockPkg::CLOSED;  // relock
					nextTries = 4'd0;
				end
				default:
				begin
					nextState = lockPkg::LOCKOUT;  // only reset gets out
				end
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= lockPkg::CLOSED;
			tries <= 4'd0;
		end
		else
		begin
			state <= nextState;
			tries <= nextTries;
		end
	end

	// buffer is emptied at every enter, whatever the outcome
	assign entryFlush = enter;
	assign keyEnable  = (state != lockPkg::LOCKOUT);
	assign unlocked   = (state == lockPkg::OPEN);
	assign lockedOut  = (state == lockPkg::LOCKOUT);

	always_comb
	begin
		case (state)
			lockPkg::OPEN:    statusGlyph = lockPkg::glyphP;
			lockPkg::LOCKOUT: statusGlyph = lockPkg::glyphDash;
			default:          statusGlyph = lockPkg::glyphT'(tries);  // stays below ten
		endcase
	end

	// unfilled positions stay blank
	always_comb
	begin
		display.digit3 = statusGlyph;
		display.digit2 = lockPkg::glyphBlank;
		display.digit1 = lockPkg::glyphBlank;
		display.digit0 = lockPkg::glyphBlank;
		if (entryCount >= 2'd1)
		begin
			display.digit0 = entryCode[3:0];
		end
		if (entryCount >= 2'd2)
		begin
			display.digit1 = entryCode[7:4];
		end
		if (entryCount == 2'd3)
		begin
			display.digit2 = entryCode[11:8];
		end
	end

endmodule

// ==== verilog/segmentEncoder.sv ====
module segmentEncoder
(
	input  lockPkg::glyphT    glyph,
	output lockPkg::segmentsT pattern
);

	// common cathode, a segment lights on a 1
	always_comb
	begin
		case (glyph)
			4'h0:    pattern = 8'h3f;
			4'h1:    pattern = 8'h06;
			4'h2:    pattern = 8'h5b;
			4'h3:    pattern = 8'h4f;
			4'h4:    pattern = 8'h66;
			4'h5:    pattern = 8'h6d;
			4'h6:    pattern = 8'h7d;
			4'h7:    pattern = 8'h07;
			4'h8:    pattern = 8'h7f;
			4'h9:    pattern = 8'h6f;
			4'ha:    pattern = 8'h73;  // P
			4'hb:    pattern = 8'h77;  // A
			4'hc:    pattern = 8'h6d;  // S, same as five
			4'hd:    pattern = 8'h40;  // dash, segment g only
			4'he:    pattern = 8'h00;
			default: pattern = 8'h00;  // blank
		endcase
	end

endmodule

// ==== verilog/digitScanner.sv ====
module digitScanner
#(
	parameter int scanDiv = 50000
)
(
	input  logic                    CLK,
	input  logic                    reset,
	input  lockPkg::segmentsT [3:0] patterns,
	output lockPkg::segmentsT       segments,
	output lockPkg::digitSelT       digitSel
);

	localparam int divW = (scanDiv > 1) ? $clog2(scanDiv) : 1;
	localparam logic [divW-1:0] divLast = divW'(scanDiv - 1);

	logic [divW-1:0] divCount;
	logic            tick;
	logic [1:0]      index;
	logic [1:0]      nextIndex;

	// last cycle of the current digit
	assign tick      = (divCount == divLast);
	assign nextIndex = tick ? index + 2'd1 : index;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			divCount <= '0;
		end
		else if (tick)
		begin
			divCount <= '0;
		end
		else
		begin
			divCount <= divCount + 1'b1;
		end
	end

	// index and select move on the same edge
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			index    <= 2'd0;
			digitSel <= 4'b1110;
		end
		else
		begin
			index    <= nextIndex;
			digitSel <= ~(4'b0001 << nextIndex);  // one-cold
		end
	end

	// pattern follows the index that the select will show
	always_ff @(posedge CLK)
	begin
		segments <= patterns[nextIndex];
	end

endmodule

// ==== verilog/codeLockTop.sv ====
module codeLockTop
#(
	parameter lockPkg::codeWordT secretCode = 12'h3a7,
	parameter lockPkg::triesT    maxTries   = 4'd6,
	parameter int                scanDiv    = 50000
)
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              keyValid,
	input  lockPkg::hexDigitT keyValue,
	input  logic              enter,
	input  logic              clear,
	output lockPkg::segmentsT segments,
	output lockPkg::digitSelT digitSel,
	output logic              unlocked,
	output logic              lockedOut
);

	lockPkg::codeWordT       entryCode;
	logic [1:0]              entryCount;
	logic                    entryFlush;
	logic                    keyEnable;
	lockPkg::displayT        display;
	lockPkg::segmentsT [3:0] patterns;

	codeEntry i_codeEntry
	(
		.CLK        (CLK),
		.reset      (reset),
		.keyValid   (keyValid),
		.keyValue   (keyValue),
		.clear      (clear),
		.flush      (entryFlush),
		.keyEnable  (keyEnable),
		.entryCode  (entryCode),
		.entryCount (entryCount)
	);

	lockController
	#(
		.secretCode (secretCode),
		.maxTries   (maxTries)
	)
	i_lockController
	(
		.CLK        (CLK),
		.reset      (reset),
		.enter      (enter),
		.entryCode  (entryCode),
		.entryCount (entryCount),
		.entryFlush (entryFlush),
		.keyEnable  (keyEnable),
		.unlocked   (unlocked),
		.lockedOut  (lockedOut),
		.display    (display)
	);

	// one encoder per display position, field k to pattern k
	genvar k;
	generate
		for (k = 0; k < 4; k++)
		begin : g_encoder
			segmentEncoder i_segmentEncoder
			(
				.glyph   (display[4*k +: 4]),
				.pattern (patterns[k])
			);
		end
	endgenerate

	digitScanner
	#(
		.scanDiv (scanDiv)
	)
	i_digitScanner
	(
		.CLK      (CLK),
		.reset    (reset),
		.patterns (patterns),
		.segments (segments),
		.digitSel (digitSel)
	);

endmodule

// ==== tests/codeLockTb.sv ====
module codeLockTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam lockPkg::codeWordT secret   = 12'h3a7;
	localparam lockPkg::triesT    maxTries = 4'd6;
	localparam int                scanDiv  = 4;

	logic              CLK;
	logic              reset;
	logic              keyValid;
	lockPkg::hexDigitT keyValue;
	logic              enter;
	logic              clear;
	lockPkg::segmentsT segments;
	lockPkg::digitSelT digitSel;
	logic              unlocked;
	logic              lockedOut;

	// reference model of the lock
	lockPkg::lockStateT modelState;
	lockPkg::triesT     modelTries;
	lockPkg::codeWordT  modelCode;
	logic [1:0]         modelCount;
	lockPkg::displayT   modelDisplay;
	lockPkg::displayT   lagDisplay;
	lockPkg::segmentsT  expectSegments;

	lockPkg::digitSelT prevSel;
	lockPkg::digitSelT lastCapSel;
	int                holdCount;
	lockPkg::segmentsT shadow [4];
	int                scanCount = 0;
	logic [7:0]        lfsr;
	int                errorCount = 0;
	int                testCount = 0;
	int                testErrors = 0;
	lockPkg::codeWordT wrongCode;

	codeLockTop
	#(
		.secretCode (secret),
		.maxTries   (maxTries),
		.scanDiv    (scanDiv)
	)
	i_dut
	(
		.CLK       (CLK),
		.reset     (reset),
		.keyValid  (keyValid),
		.keyValue  (keyValue),
		.enter     (enter),
		.clear     (clear),
		.segments  (segments),
		.digitSel  (digitSel),
		.unlocked  (unlocked),
		.lockedOut (lockedOut)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// common cathode reference patterns
	function automatic lockPkg::segmentsT glyphPattern(input lockPkg::glyphT glyph);
		case (glyph)
			4'h0:    return 8'h3f;
			4'h1:    return 8'h06;
			4'h2:    return 8'h5b;
			4'h3:    return 8'h4f;
			4'h4:    return 8'h66;
			4'h5:    return 8'h6d;
			4'h6:    return 8'h7d;
			4'h7:    return 8'h07;
			4'h8:    return 8'h7f;
			4'h9:    return 8'h6f;
			4'ha:    return 8'h73;  // P
			4'hb:    return 8'h77;
			4'hc:    return 8'h6d;
			4'hd:    return 8'h40;  // dash
			default: return 8'h00;
		endcase
	endfunction

	function automatic int selIndex(input lockPkg::digitSelT sel);
		int k;
		selIndex = 0;
		for (k = 0; k < 4; k++)
			if (!sel[k])
				selIndex = k;
	endfunction

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	always @(posedge CLK)
	begin
		if (reset)
		begin
			modelState <= lockPkg::CLOSED;
			modelTries <= 4'd0;
			modelCount <= 2'd0;
		end
		else
		begin
			if (enter || clear)
				modelCount <= 2'd0;
			else if (keyValid && modelState != lockPkg::LOCKOUT)
			begin
				modelCode <= {modelCode[7:0], keyValue};
				if (modelCount != 2'd3)
					modelCount <= modelCount + 2'd1;
			end
			if (enter && modelState == lockPkg::OPEN)
			begin
				modelState <= lockPkg::CLOSED;
				modelTries <= 4'd0;
			end
			else if (enter && modelState == lockPkg::CLOSED)
			begin
				if (modelCount == 2'd3 && modelCode == secret)
				begin
					modelState <= lockPkg::OPEN;
					modelTries <= 4'd0;
				end
				else
				begin
					modelTries <= modelTries + 4'd1;
					if (modelTries + 4'd1 == maxTries)
						modelState <= lockPkg::LOCKOUT;
				end
			end
		end
	end

	always_comb
	begin
		case (modelState)
			lockPkg::OPEN:    modelDisplay.digit3 = lockPkg::glyphP;
			lockPkg::LOCKOUT: modelDisplay.digit3 = lockPkg::glyphDash;
			default:          modelDisplay.digit3 = modelTries;
		endcase
		modelDisplay.digit2 = (modelCount == 2'd3) ? modelCode[11:8] : lockPkg::glyphBlank;
		modelDisplay.digit1 = (modelCount >= 2'd2) ? modelCode[7:4] : lockPkg::glyphBlank;
		modelDisplay.digit0 = (modelCount >= 2'd1) ? modelCode[3:0] : lockPkg::glyphBlank;
	end

	// segments lag the display by one register stage
	always @(posedge CLK)
	begin
		lagDisplay <= modelDisplay;
		prevSel    <= reset ? 4'b1110 : digitSel;
		if (reset)
			holdCount <= 0;
		else if (digitSel != prevSel)
			holdCount <= 1;
		else
			holdCount <= holdCount + 1;
	end

	assign expectSegments = glyphPattern(lagDisplay[4*selIndex(digitSel) +: 4]);

	// shadow display capture
	always @(negedge CLK)
	begin
		for (int k = 0; k < 4; k++)
			if (!digitSel[k])
				shadow[k] <= segments;
		if (!digitSel[3] && lastCapSel[3])
			scanCount <= scanCount + 1;  // one scan per digit 3 start
		lastCapSel <= digitSel;
	end

	task automatic reportValue(input string name, input int expected, input int actual);
		$display("** Error at %0d ns: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual);
		errorCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("Failure at %0d ns: %s", $time, text);
		errorCount++;
	endtask

	assert property (@(posedge CLK) disable iff (reset)
		unlocked == (modelState == lockPkg::OPEN))
		else reportValue("unlocked", $sampled(modelState == lockPkg::OPEN),
			$sampled(unlocked));

	assert property (@(posedge CLK) disable iff (reset)
		lockedOut == (modelState == lockPkg::LOCKOUT))
		else reportValue("lockedOut", $sampled(modelState == lockPkg::LOCKOUT),
			$sampled(lockedOut));

	assert property (@(posedge CLK) disable iff (reset) $onehot(~digitSel))
		else reportProblem("digit select is not one-cold");

	assert property (@(posedge CLK) disable iff (reset) segments == expectSegments)
		else reportValue("segments", $sampled(expectSegments), $sampled(segments));

	assert property (@(posedge CLK) disable iff (reset) (digitSel != prevSel) |->
		(digitSel == {prevSel[2:0], prevSel[3]} && holdCount == scanDiv))
		else reportProblem("digit select did not rotate after exactly scanDiv cycles");

	task automatic stepClock();
		@(posedge CLK);
		#2;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (2) @(posedge CLK);
		#2;
		reset = 1'b0;
	endtask

	task automatic pressKey(input lockPkg::hexDigitT digit);
		keyValid = 1'b1;
		keyValue = digit;
		stepClock();
		keyValid = 1'b0;
	endtask

	task automatic pressEnter();
		enter = 1'b1;
		stepClock();
		enter = 1'b0;
	endtask

	task automatic pressClear();
		clear = 1'b1;
		stepClock();
		clear = 1'b0;
	endtask

	// oldest digit goes in first and ends up in digit 2
	task automatic keyCode(input lockPkg::codeWordT code);
		pressKey(code[11:8]);
		pressKey(code[7:4]);
		pressKey(code[3:0]);
	endtask

	task automatic drawWrongCode(output lockPkg::codeWordT code);
		do
		begin
			for (int b = 0; b < 12; b++)
			begin
				lfsr = lfsrStep(lfsr);
				code = {code[10:0], lfsr[7]};
			end
		end
		while (code == secret);
	endtask

	task automatic waitScan();
		int start;
		int cycles;
		stepClock();  // let the registered segments catch up
		start = scanCount;
		cycles = 0;
		while (scanCount < start + 2 && cycles < 16 * scanDiv)
		begin
			stepClock();
			cycles++;
		end
		if (scanCount < start + 2)
			reportProblem("timeout waiting for a full display scan");
	endtask

	task automatic waitStatus(input logic wantOpen, input logic wantLocked, input string what);
		int cycles;
		cycles = 0;
		while ((unlocked !== wantOpen || lockedOut !== wantLocked) && cycles < 8)
		begin
			stepClock();
			cycles++;
		end
		if (unlocked !== wantOpen || lockedOut !== wantLocked)
			reportProblem({"timeout waiting for ", what});
	endtask

	// expected holds digit 3 in the top byte
	task automatic expectShadow(input logic [31:0] expected);
		waitScan();
		for (int k = 0; k < 4; k++)
			assert (shadow[k] == expected[8*k +: 8])
			else reportValue($sformatf("shadow digit %0d", k), expected[8*k +: 8],
				shadow[k]);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	initial
	begin
		keyValid = 1'b0;
		keyValue = 4'h0;
		enter    = 1'b0;
		clear    = 1'b0;
		lfsr     = 8'd83;
		applyReset();

		waitStatus(1'b0, 1'b0, "idle after reset");
		expectShadow(32'h3f000000);
		finishTest("reset");

		keyCode(12'h3a7);
		expectShadow(32'h3f4f7307);
		pressKey(4'h1);
		expectShadow(32'h3f730706);
		pressClear();
		expectShadow(32'h3f000000);
		finishTest("entry");

		keyCode(secret);
		pressEnter();
		waitStatus(1'b1, 1'b0, "unlock");
		expectShadow(32'h73000000);
		pressEnter();
		waitStatus(1'b0, 1'b0, "relock");
		expectShadow(32'h3f000000);
		finishTest("correct code");

		for (int i = 1; i <= 4; i++)
		begin
			drawWrongCode(wrongCode);
			keyCode(wrongCode);
			pressEnter();
			expectShadow({glyphPattern(lockPkg::glyphT'(i)), 24'h0});
		end
		pressKey(4'h3);
		pressKey(4'ha);
		pressEnter();
		expectShadow({glyphPattern(4'd5), 24'h0});  // short entry counts as wrong
		finishTest("wrong codes");

		drawWrongCode(wrongCode);
		keyCode(wrongCode);
		pressEnter();
		waitStatus(1'b0, 1'b1, "lockout");
		expectShadow(32'h40000000);
		keyCode(secret);
		expectShadow(32'h40000000);
		pressEnter();
		stepClock();
		assert (!unlocked)
		else reportValue("unlocked", 0, unlocked);
		applyReset();
		waitStatus(1'b0, 1'b0, "release by reset");
		expectShadow(32'h3f000000);
		finishTest("lockout");

		waitScan();
		waitScan();
		finishTest("scan order");

		$display("tests: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/lockPkg.sv
verilog/codeEntry.sv
verilog/lockController.sv
verilog/segmentEncoder.sv
verilog/digitScanner.sv
verilog/codeLockTop.sv
tests/codeLockTb.sv

// ==== Makefile ====
TOP = codeLockTb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
